/* lsuTop.f */
+incdir+include
source/lsuPkg.sv
source/loadStoreBuffer.sv
source/dataCache.sv
source/memCtrl.sv
source/lsuTop.sv
sim/clockGen.sv
sim/lsuTopTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the load/store path testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module lsuTopTb \
    -f lsuTop.f \
    -o lsuSim

./obj_dir/lsuSim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi

echo "run finished, see sim.log"

/* sim/lsuTopTb.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsuTopTb;
    import lsuPkg::*;

    typedef struct packed {
        logic [2:0]         testId;
        lsOp_e              op;
        memLen_e            len;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic [`WAIT_W-1:0] waitCycles;
        logic [3:0]         gap;
        logic               stall;
    } stimRow_t;

    logic               clk;
    logic               rst;
    logic               rdy;
    logic [`WAIT_W-1:0] memWait;
    logic               issueValid;
    memReq_t            issueReq;
    logic               issueFull;
    logic               doneValid;
    memResp_t           doneResp;

    stimRow_t           rows [$];
    logic [7:0]         model [`RAM_BYTES];   // reference copy of the RAM.
    logic [`DATA_W-1:0] expData [$];
    logic [`TAG_W-1:0]  expTag [$];
    logic [`TAG_W-1:0]  nextTag;
    int                 errCount;
    int                 testErr;
    int                 issuedCount;
    int                 recvCount;
    int                 testsRun;
    int                 testsFailed;
    int                 cycleCount = 0;
    int                 cycleLimit = 0;
    logic               sawFull;
    int                 fullAt;
    string              testName [1:5];

    clockGen uClock (
        .clk (clk),
        .rst (rst)
    );

    lsuTop DUT (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .memWait    (memWait),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .issueFull  (issueFull),
        .doneValid  (doneValid),
        .doneResp   (doneResp)
    );

    task automatic logError(input string line);
        errCount++;
        testErr++;
        $display("%s", line);
    endtask

    task automatic addRow(input logic [2:0] id, input lsOp_e op, input memLen_e len,
                          input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] w, input logic [3:0] gap, input logic stall);
        rows.push_back(stimRow_t'{id, op, len, addr, data, w, gap, stall});
    endtask

    function automatic int byteCount(input memLen_e len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian gather, upper bytes left zero.
    function automatic logic [31:0] modelLoad(input logic [7:0] addr, input int nBytes);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < nBytes; i++) begin
            word[8*i +: 8] = model[addr + 8'(i)];   // wraps past 255.
        end
        return word;
    endfunction

    task automatic buildTable();
        addRow(3'd1, opStore, lenWord, 8'h10, $urandom, 4'd2, 4'd0, 1'b0);
        addRow(3'd1, opLoad,  lenWord, 8'h10, 32'h0,    4'd2, 4'd0, 1'b0);
        addRow(3'd2, opStore, lenWord, 8'h20, $urandom,     4'd1, 4'd0, 1'b0);
        addRow(3'd2, opStore, lenByte, 8'h21, 32'hFFFF_FFA5, 4'd0, 4'd1, 1'b0);
        addRow(3'd2, opStore, lenHalf, 8'h22, 32'h1234_C3B2, 4'd3, 4'd0, 1'b0);
        addRow(3'd2, opLoad,  lenByte, 8'h20, 32'h0,         4'd0, 4'd0, 1'b0);
        addRow(3'd2, opLoad,  lenByte, 8'h23, 32'h0,         4'd1, 4'd2, 1'b0);
        addRow(3'd2, opLoad,  lenHalf, 8'h21, 32'h0,         4'd0, 4'd0, 1'b0);
        addRow(3'd2, opLoad,  lenWord, 8'h20, 32'h0,         4'd3, 4'd0, 1'b0);
        addRow(3'd2, opStore, lenWord, 8'hFE, $urandom,      4'd1, 4'd0, 1'b0);
        addRow(3'd2, opLoad,  lenWord, 8'hFE, 32'h0,         4'd0, 4'd0, 1'b0);
        addRow(3'd2, opLoad,  lenHalf, 8'hFF, 32'h0,         4'd2, 4'd0, 1'b0);
        // twelve requests so far, so tags restart at zero here.
        addRow(3'd3, opStore, lenWord, 8'h40, $urandom, 4'd0, 4'd0, 1'b0);
        addRow(3'd3, opStore, lenWord, 8'h44, $urandom, 4'd0, 4'd0, 1'b0);
        addRow(3'd3, opStore, lenHalf, 8'h48, $urandom, 4'd0, 4'd0, 1'b0);
        addRow(3'd3, opStore, lenByte, 8'h4A, $urandom, 4'd0, 4'd0, 1'b0);
        addRow(3'd3, opLoad,  lenWord, 8'h40, 32'h0,    4'd0, 4'd0, 1'b0);
        addRow(3'd3, opLoad,  lenWord, 8'h44, 32'h0,    4'd0, 4'd0, 1'b0);
        addRow(3'd3, opLoad,  lenHalf, 8'h48, 32'h0,    4'd0, 4'd0, 1'b0);
        addRow(3'd3, opLoad,  lenByte, 8'h4A, 32'h0,    4'd0, 4'd0, 1'b0);
        addRow(3'd4, opStore, lenWord, 8'h60, $urandom, 4'd15, 4'd0, 1'b0);
        addRow(3'd4, opStore, lenWord, 8'h64, $urandom, 4'd15, 4'd0, 1'b0);
        addRow(3'd4, opStore, lenHalf, 8'h68, $urandom, 4'd15, 4'd0, 1'b0);
        addRow(3'd4, opLoad,  lenWord, 8'h60, 32'h0,    4'd15, 4'd0, 1'b0);
        addRow(3'd4, opLoad,  lenWord, 8'h64, 32'h0,    4'd15, 4'd0, 1'b0);
        addRow(3'd4, opLoad,  lenHalf, 8'h68, 32'h0,    4'd15, 4'd0, 1'b0);
        addRow(3'd5, opStore, lenWord, 8'h80, $urandom, 4'd8, 4'd0, 1'b0);
        // short enough to finish inside the stall window if rdy froze nothing.
        addRow(3'd5, opLoad,  lenWord, 8'h80, 32'h0,    4'd2, 4'd0, 1'b1);
    endtask

    task automatic waitDrain();
        while (expData.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // freeze the whole path with the request part way through memCtrl.
    task automatic stallRdy();
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        rdy = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (doneValid) begin
                logError("doneValid went high while rdy was held low");
            end
        end
        @(posedge clk);
        #1;
        rdy = 1'b1;
    endtask

    task automatic issueRow(input stimRow_t r);
        int nBytes;
        nBytes = byteCount(r.len);
        if (r.stall) begin
            waitDrain();   // stalled request must be alone in flight.
        end
        while (issueFull) begin
            if (!sawFull) begin
                sawFull = 1'b1;
                fullAt = issuedCount;
            end
            @(posedge clk);
            #1;
        end
        memWait = r.waitCycles;
        issueReq.op = r.op;
        issueReq.len = r.len;
        issueReq.addr = r.addr;
        issueReq.data = r.data;
        issueReq.tag = '1;   // must be replaced by the buffer.
        if (r.op == opStore) begin
            for (int i = 0; i < nBytes; i++) begin
                model[r.addr + 8'(i)] = r.data[8*i +: 8];
            end
            expData.push_back('0);
        end else begin
            expData.push_back(modelLoad(r.addr, nBytes));
        end
        expTag.push_back(nextTag);
        nextTag = nextTag + 1'b1;
        issuedCount++;
        issueValid = 1'b1;
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        if (r.stall) begin
            stallRdy();
        end
        repeat (r.gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic endTest(input string label);
        testsRun++;
        if (testErr != 0) begin
            testsFailed++;
        end
        $display("test %s: %0d requests, %0d errors", label, issuedCount, testErr);
    endtask

    task automatic checkReset();
        testErr = 0;
        issuedCount = 0;
        wait (rst == 1'b0);
        @(negedge clk);
        if (issueFull !== 1'b0) begin
            logError($sformatf("ERR issueFull: expected 0, got %0h", issueFull));
        end
        if (doneValid !== 1'b0) begin
            logError($sformatf("ERR doneValid: expected 0, got %0h", doneValid));
        end
        repeat (6) begin
            @(negedge clk);
            if (doneValid) begin
                logError("doneValid pulsed after reset with nothing issued");
            end
        end
        @(posedge clk);
        #1;
        endTest("6 reset state");
    endtask

    task automatic runTest(input logic [2:0] id);
        testErr = 0;
        issuedCount = 0;
        recvCount = 0;
        sawFull = 1'b0;
        fullAt = 0;
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].testId == id) begin
                issueRow(rows[i]);
            end
        end
        waitDrain();
        if (recvCount != issuedCount) begin
            logError($sformatf("%0d requests issued but %0d results came back",
                               issuedCount, recvCount));
        end
        if (id == 3'd4) begin
            if (!sawFull) begin
                logError("issueFull never rose under back-pressure");
            end else if (fullAt > `LSB_DEPTH + 1) begin
                logError($sformatf("issueFull rose only after %0d accepted requests", fullAt));
            end
            if (issueFull !== 1'b0) begin
                logError($sformatf("ERR issueFull: expected 0, got %0h", issueFull));
            end
        end
        endTest($sformatf("%0d %s", id, testName[id]));
    endtask

    // responses are checked mid-cycle, in issue order.
    always @(negedge clk) begin
        if (!rst && rdy && doneValid) begin
            if (expData.size() == 0) begin
                logError("doneValid pulsed with no request outstanding");
            end else begin
                if (doneResp.data !== expData[0]) begin
                    logError($sformatf("ERR doneResp.data: expected %08h, got %08h",
                                       expData[0], doneResp.data));
                end
                if (doneResp.tag !== expTag[0]) begin
                    logError($sformatf("ERR doneResp.tag: expected %0h, got %0h",
                                       expTag[0], doneResp.tag));
                end
                void'(expData.pop_front());
                void'(expTag.pop_front());
                recvCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: run went past its limit of %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rdy = 1'b1;
        memWait = '0;
        issueValid = 1'b0;
        issueReq = '0;
        void'($urandom(34956));
        nextTag = '0;
        errCount = 0;
        testsRun = 0;
        testsFailed = 0;
        testName[1] = "store then load word";
        testName[2] = "byte and half access with wrap";
        testName[3] = "tag order";
        testName[4] = "back-pressure";
        testName[5] = "rdy stall";
        buildTable();
        cycleLimit = 200;
        for (int i = 0; i < rows.size(); i++) begin
            cycleLimit += 4 * (int'(rows[i].waitCycles) + 1) + 10;
            cycleLimit += int'(rows[i].gap) + 20 * int'(rows[i].stall);
        end
        checkReset();
        for (int t = 1; t <= 5; t++) begin
            runTest(3'(t));
        end
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);
    localparam int HalfPeriod = 50;   // 100 ns clock.
    localparam int ResetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // release lands just after an edge, like the other inputs.
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* source/lsuTop.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsuTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic [`WAIT_W-1:0] memWait,
    input  logic               issueValid,
    input  lsuPkg::memReq_t    issueReq,
    output logic               issueFull,
    output logic               doneValid,
    output lsuPkg::memResp_t   doneResp
);
    import lsuPkg::*;

    logic               sendValid;
    memReq_t            sendReq;
    logic               cacheBusy;
    logic               mcStart;
    memReq_t            mcReq;
    logic               mcDone;
    logic [`DATA_W-1:0] mcData;

    loadStoreBuffer uBuffer (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .issueFull  (issueFull),
        .cacheBusy  (cacheBusy),
        .sendValid  (sendValid),
        .sendReq    (sendReq)
    );

    dataCache uCache (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .sendValid (sendValid),
        .sendReq   (sendReq),
        .cacheBusy (cacheBusy),
        .mcStart   (mcStart),
        .mcReq     (mcReq),
        .mcDone    (mcDone),
        .mcData    (mcData),
        .doneValid (doneValid),
        .doneResp  (doneResp)
    );

    memCtrl uMemCtrl (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .memWait (memWait),
        .mcStart (mcStart),
        .mcReq   (mcReq),
        .mcDone  (mcDone),
        .mcData  (mcData)
    );

endmodule

/* source/memCtrl.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module memCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic [`WAIT_W-1:0] memWait,
    input  logic               mcStart,
    input  lsuPkg::memReq_t    mcReq,
    output logic               mcDone,
    output logic [`DATA_W-1:0] mcData
);
    import lsuPkg::*;

    localparam int IdxW = $clog2(`DATA_W / 8);

    mcState_e           state;
    lsOp_e              curOp;
    logic [`ADDR_W-1:0] baseAddr;
    logic [`DATA_W-1:0] storeData;
    logic [`DATA_W-1:0] loadWord;
    logic [IdxW-1:0]    byteIdx;
    logic [IdxW-1:0]    lastIdx;
    logic [`WAIT_W-1:0] waitCnt;
    logic [`ADDR_W-1:0] byteAddr;
    logic               startHit;
    logic [7:0]         ram [`RAM_BYTES];

    // address wraps modulo the RAM size.
    assign byteAddr = baseAddr + `ADDR_W'(byteIdx);
    assign startHit = (state == mcIdle) && mcStart;

    // the port hides the state literal, hence the scoped name.
    assign mcDone = (state == lsuPkg::mcDone);
    assign mcData = loadWord;   // stays zero for stores.

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mcIdle;
            byteIdx <= '0;
            waitCnt <= '0;
        end else if (rdy) begin
            case (state)
                mcIdle: begin
                    if (mcStart) begin
                        byteIdx <= '0;
                        waitCnt <= memWait;
                        state   <= (memWait == '0) ? mcXfer : mcWait;
                    end
                end
                mcWait: begin
                    waitCnt <= waitCnt - 1'b1;
                    if (waitCnt == `WAIT_W'(1)) begin
                        state <= mcXfer;
                    end
                end
                mcXfer: begin
                    if (byteIdx == lastIdx) begin
                        state <= lsuPkg::mcDone;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                        waitCnt <= memWait;   // fresh wait for each byte.
                        state   <= (memWait == '0) ? mcXfer : mcWait;
                    end
                end
                default: begin
                    state <= mcIdle;   // done lasts one cycle.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (startHit) begin
                curOp     <= mcReq.op;
                baseAddr  <= mcReq.addr;
                storeData <= mcReq.data;
                loadWord  <= '0;
                case (mcReq.len)
                    lenByte: begin
                        lastIdx <= '0;
                    end
                    lenHalf: begin
                        lastIdx <= IdxW'(1);
                    end
                    default: begin
                        lastIdx <= '1;   // word.
                    end
                endcase
            end
            if (state == mcXfer) begin
                if (curOp == opStore) begin
                    ram[byteAddr] <= storeData[8*byteIdx +: 8];   // lowest byte first.
                end else begin
                    loadWord[8*byteIdx +: 8] <= ram[byteAddr];
                end
            end
        end
    end

endmodule

/* source/dataCache.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module dataCache (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               sendValid,
    input  lsuPkg::memReq_t    sendReq,
    output logic               cacheBusy,
    output logic               mcStart,
    output lsuPkg::memReq_t    mcReq,
    input  logic               mcDone,
    input  logic [`DATA_W-1:0] mcData,
    output logic               doneValid,
    output lsuPkg::memResp_t   doneResp
);

    logic              occupied;
    logic [`TAG_W-1:0] tagHeld;   // tag of the request in flight.

    // held busy through reset so the buffer cannot issue early.
    assign cacheBusy = rst || occupied;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            mcStart   <= 1'b0;
            doneValid <= 1'b0;
        end else if (rdy) begin
            mcStart   <= sendValid;   // one-cycle start.
            doneValid <= mcDone;
            if (sendValid) begin
                occupied <= 1'b1;
            end else if (mcDone) begin
                occupied <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (sendValid) begin
                mcReq   <= sendReq;
                tagHeld <= sendReq.tag;
            end
            if (mcDone) begin
                doneResp.data <= mcData;
                doneResp.tag  <= tagHeld;
            end
        end
    end

endmodule

/* source/loadStoreBuffer.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module loadStoreBuffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            issueValid,
    input  lsuPkg::memReq_t issueReq,
    output logic            issueFull,
    input  logic            cacheBusy,
    output logic            sendValid,
    output lsuPkg::memReq_t sendReq
);
    import lsuPkg::*;

    localparam int PtrW = $clog2(`LSB_DEPTH);

    memReq_t           queue [`LSB_DEPTH];
    logic [PtrW-1:0]   head;
    logic [PtrW-1:0]   tail;
    logic [PtrW:0]     count;
    logic [`TAG_W-1:0] tagCnt;
    logic              push;
    logic              pop;
    memReq_t           stamped;

    assign issueFull = (count == `LSB_DEPTH);
    assign push      = issueValid && !issueFull;   // dropped when full.

    // the cache raises busy only a cycle after it sees sendValid,
    // so a pending pulse also blocks the next pop.
    assign pop = !cacheBusy && !sendValid && (count != '0);

    always_comb begin
        stamped     = issueReq;
        stamped.tag = tagCnt;   // outside tag field ignored.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            tagCnt    <= '0;
            sendValid <= 1'b0;
        end else if (rdy) begin
            sendValid <= pop;
            if (push) begin
                tail   <= tail + 1'b1;   // wraps at depth.
                tagCnt <= tagCnt + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;   // idle or push with pop.
                end
            endcase
        end
    end

    // queue storage and the outgoing request carry no reset.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (push) begin
                queue[tail] <= stamped;
            end
            if (pop) begin
                sendReq <= queue[head];
            end
        end
    end

endmodule

/* source/lsuPkg.sv */
`include "lsu_consts.svh"

package lsuPkg;

    typedef enum logic {
        opLoad,
        opStore
    } lsOp_e;

    // access size in bytes is 1, 2 or 4.
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } memLen_e;

    typedef enum logic [1:0] {
        mcIdle,
        mcWait,
        mcXfer,
        mcDone
    } mcState_e;

    typedef struct packed {
        lsOp_e              op;
        memLen_e            len;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic [`TAG_W-1:0]  tag;   // stamped by the buffer.
    } memReq_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;   // zero for stores.
        logic [`TAG_W-1:0]  tag;
    } memResp_t;

endpackage

/* include/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// datapath widths.
`define DATA_W 32
`define ADDR_W 8

// byte-wide data memory, one byte per address.
`define RAM_BYTES 256

// tag is a wrapping sequence number over the buffer depth.
`define TAG_W 2
`define LSB_DEPTH 4

// wait states inserted before each byte access.
`define WAIT_W 4

`endif
